// ==== run.sh ====
#!/bin/sh
# Build and run the stats testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sim.f --top-module tb_stats_top \
    --Mdir obj_dir -o tb_stats_top > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_stats_top > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "TEST FAILED" sim.log; then
    exit 1
fi

exit 0

// ==== sim.f ====
verilog/stats_pkg.sv
verilog/stats_collect.sv
verilog/stats_arbiter.sv
verilog/stats_counter.sv
verilog/stats_top.sv
tests/tb_stats_top.sv

// ==== tests/tb_stats_top.sv ====
`timescale 1ns/1ps

module tb_stats_top import stats_pkg::*; ();

    logic                          clk;
    logic                          rst;
    logic [CH_COUNT*INC_WIDTH-1:0] stat_inc;
    logic [CH_COUNT-1:0]           stat_valid;
    logic                          update;
    logic                          rd_en;
    logic [STAT_ID_WIDTH-1:0]      rd_addr;
    logic [CNT_WIDTH-1:0]          rd_data;
    logic                          rd_valid;

    // every increment the DUT has seen.
    int                   inc_ch_q[$];
    logic [INC_WIDTH-1:0] inc_val_q[$];

    // reads waiting for rd_valid.
    string                rd_name_q[$];
    int                   rd_addr_q[$];
    logic [CNT_WIDTH-1:0] rd_exp_q[$];
    bit                   rd_chk_q[$];

    string                cur_name;
    int                   cur_addr;
    logic [CNT_WIDTH-1:0] cur_exp;
    bit                   cur_chk;
    logic                 rd_en_prev;  // rd_en as the last edge saw it.

    int value_errors;
    int latency_errors;
    int protocol_errors;

    stats_top dut (
        .clk        (clk),
        .rst        (rst),
        .stat_inc   (stat_inc),
        .stat_valid (stat_valid),
        .update     (update),
        .rd_en      (rd_en),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data),
        .rd_valid   (rd_valid)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // --------------------
    // reference model.
    // --------------------
    function automatic logic [CNT_WIDTH-1:0] model_counter(input int idx);
        logic [CNT_WIDTH-1:0] total;
        total = '0;
        foreach (inc_ch_q[i]) begin
            if (inc_ch_q[i] == idx) begin
                total = total + CNT_WIDTH'(inc_val_q[i]);  // wraps modulo 2^32.
            end
        end
        return total;
    endfunction

    task automatic check_count(input string name, input int idx,
                               input logic [CNT_WIDTH-1:0] expected,
                               input logic [CNT_WIDTH-1:0] actual);
        if (actual !== expected) begin
            value_errors++;
            $display("[FAIL] %s: counter %0d expected 0x%08h actual 0x%08h",
                     name, idx, expected, actual);
        end
    endtask

    task automatic check_read_latency(input logic expected, input logic actual);
        if (actual !== expected) begin
            latency_errors++;
            $display("rd_valid was %b one cycle after rd_en was %b, read latency is wrong",
                     actual, expected);
        end
    endtask

    // --------------------
    // response checking.
    // --------------------
    always @(negedge clk) begin
        if (rst === 1'b0) begin
            check_read_latency(rd_en_prev, rd_valid);
            if (rd_valid === 1'b1) begin
                if (rd_name_q.size() == 0) begin
                    protocol_errors++;
                    $display("rd_valid came back with no read outstanding");
                end else begin
                    cur_name = rd_name_q.pop_front();
                    cur_addr = rd_addr_q.pop_front();
                    cur_exp  = rd_exp_q.pop_front();
                    cur_chk  = rd_chk_q.pop_front();
                    if (cur_chk) begin
                        check_count(cur_name, cur_addr, cur_exp, rd_data);
                    end
                end
            end
        end
        rd_en_prev = rd_en;
    end

    // --------------------
    // stimulus helpers.
    // --------------------
    task automatic wait_cycle();
        @(posedge clk);
        #10;  // drive away from the edge.
    endtask

    task automatic clear_inputs();
        stat_inc   = '0;
        stat_valid = '0;
        update     = 1'b0;
        rd_en      = 1'b0;
    endtask

    task automatic log_inc(input int ch, input logic [INC_WIDTH-1:0] val);
        inc_ch_q.push_back(ch);
        inc_val_q.push_back(val);
    endtask

    task automatic drive_random_incs();
        logic [INC_WIDTH-1:0] val;
        stat_valid = CH_COUNT'($urandom);
        for (int ch = 0; ch < CH_COUNT; ch++) begin
            val = INC_WIDTH'($urandom);
            stat_inc[ch*INC_WIDTH +: INC_WIDTH] = val;
            if (stat_valid[ch]) begin
                log_inc(ch, val);
            end
        end
    endtask

    task automatic pulse_update();
        update = 1'b1;
        wait_cycle();
        update = 1'b0;
    endtask

    // flush everything and let the streams drain.
    task automatic settle();
        pulse_update();
        repeat (4*UPDATE_PERIOD) wait_cycle();
    endtask

    task automatic expect_read(input string name, input int addr, input bit check);
        rd_name_q.push_back(name);
        rd_addr_q.push_back(addr);
        rd_exp_q.push_back(model_counter(addr));
        rd_chk_q.push_back(check);
    endtask

    task automatic issue_read(input string name, input int addr, input bit check);
        rd_en   = 1'b1;
        rd_addr = STAT_ID_WIDTH'(addr);
        expect_read(name, addr, check);
        wait_cycle();
    endtask

    task automatic read_all(input string name, input bit check);
        for (int i = 0; i < CH_COUNT; i++) begin
            issue_read(name, i, check);
        end
        rd_en = 1'b0;
        repeat (2) wait_cycle();
    endtask

    // --------------------
    // tests.
    // --------------------
    initial begin
        void'($urandom(32'hd048_eb3e));
        value_errors    = 0;
        latency_errors  = 0;
        protocol_errors = 0;
        rd_en_prev      = 1'b0;
        rd_addr         = '0;
        clear_inputs();
        rst = 1'b1;
        repeat (2) @(posedge clk);
        #10;
        rst = 1'b0;
        wait_cycle();

        read_all("reset_values", 1'b1);

        // one channel of group 1 only.
        for (int cyc = 0; cyc < 12; cyc++) begin
            stat_valid    = '0;
            stat_valid[5] = 1'b1;
            stat_inc[5*INC_WIDTH +: INC_WIDTH] = INC_WIDTH'($urandom % 255 + 1);
            log_inc(5, stat_inc[5*INC_WIDTH +: INC_WIDTH]);
            wait_cycle();
        end
        clear_inputs();
        settle();
        read_all("single_channel", 1'b1);

        // both groups contend at the arbiter.
        for (int cyc = 0; cyc < 500; cyc++) begin
            drive_random_incs();
            update = ($urandom % 32 == 0);
            wait_cycle();
        end
        clear_inputs();
        settle();
        read_all("random_all", 1'b1);

        // period timer only.
        for (int cyc = 0; cyc < 30; cyc++) begin
            drive_random_incs();
            wait_cycle();
        end
        clear_inputs();
        repeat (4*UPDATE_PERIOD) wait_cycle();
        read_all("auto_flush", 1'b1);

        // reads in flight are checked for latency only.
        for (int cyc = 0; cyc < 200; cyc++) begin
            drive_random_incs();
            update = (cyc % 24 == 0);
            rd_en  = (cyc % 3 == 0);
            if (rd_en) begin
                rd_addr = STAT_ID_WIDTH'($urandom);
                expect_read("reads_in_flight", int'(rd_addr), 1'b0);
            end
            wait_cycle();
        end
        clear_inputs();
        settle();
        read_all("after_traffic", 1'b1);

        repeat (4) wait_cycle();
        if (rd_name_q.size() != 0) begin
            protocol_errors++;
            $display("%0d reads never got rd_valid back", rd_name_q.size());
        end
        $display("errors: %0d value, %0d latency, %0d protocol",
                 value_errors, latency_errors, protocol_errors);
        if (value_errors + latency_errors + protocol_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // twice the stimulus and settle time of all tests.
    initial begin
        int limit_cycles;
        limit_cycles = 2 * (1000 + 5 * 4 * UPDATE_PERIOD);
        repeat (limit_cycles) @(posedge clk);
        $display("run did not finish within %0d cycles, stopped by watchdog", limit_cycles);
        $display("TEST FAILED");
        $finish;
    end

endmodule

// ==== verilog/stats_arbiter.sv ====
`timescale 1ns/1ps

module stats_arbiter import stats_pkg::*; (
    input  logic                        clk,
    input  logic                        rst,

    input  logic [STAT_INC_WIDTH-1:0]   upd_data_0,
    input  logic [LOCAL_ID_WIDTH-1:0]   upd_id_0,
    input  logic                        upd_valid_0,
    output logic                        upd_ready_0,

    input  logic [STAT_INC_WIDTH-1:0]   upd_data_1,
    input  logic [LOCAL_ID_WIDTH-1:0]   upd_id_1,
    input  logic                        upd_valid_1,
    output logic                        upd_ready_1,

    output logic [STAT_INC_WIDTH-1:0]   cnt_data,
    output logic [STAT_ID_WIDTH-1:0]    cnt_id,
    output logic                        cnt_strobe
);

    logic [STAT_INC_WIDTH-1:0] data_arr [GROUP_COUNT];
    logic [LOCAL_ID_WIDTH-1:0] id_arr [GROUP_COUNT];
    logic [GROUP_COUNT-1:0]    valid_arr;
    logic [GROUP_COUNT-1:0]    grant;

    // group index forms the top bits of the full id.
    logic [STAT_ID_WIDTH-LOCAL_ID_WIDTH-1:0] rr_ptr;     // group with priority.
    logic [STAT_ID_WIDTH-LOCAL_ID_WIDTH-1:0] grant_idx;

    assign data_arr[0] = upd_data_0;
    assign data_arr[1] = upd_data_1;
    assign id_arr[0]   = upd_id_0;
    assign id_arr[1]   = upd_id_1;
    assign valid_arr   = {upd_valid_1, upd_valid_0};

    assign upd_ready_0 = grant[0];
    assign upd_ready_1 = grant[1];

    // --------------------
    // round-robin grant.
    // --------------------
    always_comb begin
        logic [STAT_ID_WIDTH-LOCAL_ID_WIDTH-1:0] idx;

        grant     = '0;
        grant_idx = rr_ptr;
        // first valid group at or after the pointer wins.
        for (int i = 0; i < GROUP_COUNT; i++) begin
            idx = rr_ptr + i[STAT_ID_WIDTH-LOCAL_ID_WIDTH-1:0];
            if (valid_arr[idx] && grant == '0) begin
                grant[idx] = 1'b1;
                grant_idx  = idx;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rr_ptr     <= '0;
            cnt_strobe <= 1'b0;
        end else begin
            cnt_strobe <= |grant;
            if (|grant) begin
                rr_ptr <= grant_idx + 1'b1;  // winner drops to lowest priority.
            end
        end
    end

    // accepted item, presented one cycle after the handshake.
    always_ff @(posedge clk) begin
        if (|grant) begin
            cnt_data <= data_arr[grant_idx];
            cnt_id   <= {grant_idx, id_arr[grant_idx]};
        end
    end

endmodule

// ==== verilog/stats_collect.sv ====
`timescale 1ns/1ps

module stats_collect import stats_pkg::*; (
    input  logic                                clk,
    input  logic                                rst,
    input  logic [CH_PER_GROUP*INC_WIDTH-1:0]   inc,
    input  logic [CH_PER_GROUP-1:0]             inc_valid,
    input  logic                                update,
    output logic [STAT_INC_WIDTH-1:0]           upd_data,
    output logic [LOCAL_ID_WIDTH-1:0]           upd_id,
    output logic                                upd_valid,
    input  logic                                upd_ready
);

    collect_state_t state_reg, state_next;

    logic [LOCAL_ID_WIDTH-1:0] ch_reg, ch_next;      // channel under sweep.
    logic [PERIOD_WIDTH-1:0]   period_reg, period_next;
    logic [CH_PER_GROUP-1:0]   zero_reg, zero_next;  // memory entry not yet written.
    logic [CH_PER_GROUP-1:0]   flush_reg, flush_next;

    logic [STAT_INC_WIDTH-1:0] data_reg, data_next;
    logic [LOCAL_ID_WIDTH-1:0] id_reg, id_next;
    logic                      valid_reg, valid_next;

    logic [ACC_WIDTH-1:0]      acc [CH_PER_GROUP];
    logic [CH_PER_GROUP-1:0]   acc_clear;

    logic [STAT_INC_WIDTH-1:0] mem [CH_PER_GROUP];
    logic [STAT_INC_WIDTH-1:0] mem_rd_data;
    logic                      mem_rd_en;
    logic                      mem_wr_en;
    logic [STAT_INC_WIDTH-1:0] mem_wr_data;

    logic [STAT_INC_WIDTH-1:0] sum;  // held value plus accumulator.

    assign upd_data  = data_reg;
    assign upd_id    = id_reg;
    assign upd_valid = valid_reg;

    // --------------------
    // per-channel accumulators.
    // --------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < CH_PER_GROUP; i++) begin
                acc[i] <= '0;
            end
        end else begin
            for (int i = 0; i < CH_PER_GROUP; i++) begin
                if (acc_clear[i]) begin
                    // restart with this cycle's increment, if any.
                    if (inc_valid[i]) begin
                        acc[i] <= ACC_WIDTH'(inc[i*INC_WIDTH +: INC_WIDTH]);
                    end else begin
                        acc[i] <= '0;
                    end
                end else if (inc_valid[i]) begin
                    acc[i] <= acc[i] + ACC_WIDTH'(inc[i*INC_WIDTH +: INC_WIDTH]);
                end
            end
        end
    end

    // first visit ignores stale memory contents.
    assign sum = zero_reg[ch_reg] ? STAT_INC_WIDTH'(acc[ch_reg])
                                  : mem_rd_data + STAT_INC_WIDTH'(acc[ch_reg]);

    // --------------------
    // sweep and flush control.
    // --------------------
    always_comb begin
        state_next  = COLLECT_READ;
        ch_next     = ch_reg;
        period_next = period_reg;
        zero_next   = zero_reg;
        flush_next  = flush_reg;

        data_next   = data_reg;
        id_next     = id_reg;
        valid_next  = valid_reg && !upd_ready;  // drops after transfer.

        acc_clear   = '0;
        mem_rd_en   = 1'b0;
        mem_wr_en   = 1'b0;
        mem_wr_data = sum;  // fold by default.

        case (state_reg)
            COLLECT_READ: begin
                mem_rd_en  = 1'b1;
                state_next = COLLECT_WRITE;
            end
            COLLECT_WRITE: begin
                mem_wr_en         = 1'b1;
                acc_clear[ch_reg] = 1'b1;
                if (!valid_reg && flush_reg[ch_reg]) begin
                    // move total to the output register.
                    flush_next[ch_reg] = 1'b0;
                    mem_wr_data        = '0;
                    data_next          = sum;
                    id_next            = ch_reg;
                    valid_next         = sum != '0;  // zero totals stay silent.
                end
                zero_next[ch_reg] = 1'b0;

                if (ch_reg == LOCAL_ID_WIDTH'(CH_PER_GROUP-1)) begin
                    ch_next = '0;
                end else begin
                    ch_next = ch_reg + 1'b1;
                end
                state_next = COLLECT_READ;
            end
            default: begin
                state_next = COLLECT_READ;
            end
        endcase

        if (period_reg == '0) begin
            flush_next  = '1;
            period_next = PERIOD_WIDTH'(UPDATE_PERIOD-1);
        end else begin
            period_next = period_reg - 1'b1;
        end

        if (update) begin
            flush_next = '1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_reg  <= COLLECT_READ;
            ch_reg     <= '0;
            period_reg <= PERIOD_WIDTH'(UPDATE_PERIOD-1);
            zero_reg   <= '1;
            flush_reg  <= '0;
            valid_reg  <= 1'b0;
        end else begin
            state_reg  <= state_next;
            ch_reg     <= ch_next;
            period_reg <= period_next;
            zero_reg   <= zero_next;
            flush_reg  <= flush_next;
            valid_reg  <= valid_next;
        end
    end

    // output payload.
    always_ff @(posedge clk) begin
        data_reg <= data_next;
        id_reg   <= id_next;
    end

    // --------------------
    // holding memory.
    // --------------------
    always_ff @(posedge clk) begin
        if (mem_wr_en) begin
            mem[ch_reg] <= mem_wr_data;
        end else if (mem_rd_en) begin
            mem_rd_data <= mem[ch_reg];
        end
    end

endmodule

// ==== verilog/stats_counter.sv ====
`timescale 1ns/1ps

module stats_counter import stats_pkg::*; (
    input  logic                        clk,
    input  logic                        rst,

    // update strobe from the arbiter.
    input  logic [STAT_INC_WIDTH-1:0]   cnt_data,
    input  logic [STAT_ID_WIDTH-1:0]    cnt_id,
    input  logic                        cnt_strobe,

    // host read port.
    input  logic                        rd_en,
    input  logic [STAT_ID_WIDTH-1:0]    rd_addr,
    output logic [CNT_WIDTH-1:0]        rd_data,
    output logic                        rd_valid
);

    logic [CNT_WIDTH-1:0] cnt_reg [CH_COUNT];
    logic [CNT_WIDTH-1:0] cnt_sum;

    // wraps modulo 2^32.
    assign cnt_sum = cnt_reg[cnt_id] + CNT_WIDTH'(cnt_data);

    // --------------------
    // counter bank.
    // --------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < CH_COUNT; i++) begin
                cnt_reg[i] <= '0;
            end
        end else if (cnt_strobe) begin
            cnt_reg[cnt_id] <= cnt_sum;
        end
    end

    // --------------------
    // read port.
    // --------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rd_en;  // one cycle after the strobe.
        end
    end

    // sampled before any same-cycle update lands.
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= cnt_reg[rd_addr];
        end
    end

endmodule

// ==== verilog/stats_pkg.sv ====
package stats_pkg;

    // --------------------
    // channel layout.
    // --------------------
    localparam int GROUP_COUNT    = 2;   // collector groups.
    localparam int CH_PER_GROUP   = 4;   // channels per group.
    localparam int CH_COUNT       = 8;   // all channels.

    // --------------------
    // widths.
    // --------------------
    localparam int INC_WIDTH      = 8;   // per-cycle increment.
    localparam int LOCAL_ID_WIDTH = 2;   // channel index within a group.
    localparam int STAT_ID_WIDTH  = 3;   // group index on top of local id.
    localparam int STAT_INC_WIDTH = 16;  // aggregated update value.

    // holds up to eight full increments between sweep visits.
    localparam int ACC_WIDTH      = 11;

    localparam int CNT_WIDTH      = 32;  // host-visible counter.

    // --------------------
    // flush timer.
    // --------------------
    localparam int UPDATE_PERIOD  = 64;  // cycles between automatic flushes.
    localparam int PERIOD_WIDTH   = 6;

    // collector sweep alternates read and write of the holding memory.
    typedef enum logic {
        COLLECT_READ,
        COLLECT_WRITE
    } collect_state_t;

endpackage

// ==== verilog/stats_top.sv ====
`timescale 1ns/1ps

module stats_top import stats_pkg::*; (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [CH_COUNT*INC_WIDTH-1:0]   stat_inc,
    input  logic [CH_COUNT-1:0]             stat_valid,
    input  logic                            update,
    input  logic                            rd_en,
    input  logic [STAT_ID_WIDTH-1:0]        rd_addr,
    output logic [CNT_WIDTH-1:0]            rd_data,
    output logic                            rd_valid
);

    // --------------------
    // group streams.
    // --------------------
    logic [STAT_INC_WIDTH-1:0] upd_data_0, upd_data_1;
    logic [LOCAL_ID_WIDTH-1:0] upd_id_0, upd_id_1;
    logic                      upd_valid_0, upd_valid_1;
    logic                      upd_ready_0, upd_ready_1;

    // merged update strobe.
    logic [STAT_INC_WIDTH-1:0] cnt_data;
    logic [STAT_ID_WIDTH-1:0]  cnt_id;
    logic                      cnt_strobe;

    stats_collect collect_g0 (
        .clk       (clk),
        .rst       (rst),
        .inc       (stat_inc[0 +: CH_PER_GROUP*INC_WIDTH]),
        .inc_valid (stat_valid[0 +: CH_PER_GROUP]),
        .update    (update),
        .upd_data  (upd_data_0),
        .upd_id    (upd_id_0),
        .upd_valid (upd_valid_0),
        .upd_ready (upd_ready_0)
    );

    stats_collect collect_g1 (
        .clk       (clk),
        .rst       (rst),
        .inc       (stat_inc[CH_PER_GROUP*INC_WIDTH +: CH_PER_GROUP*INC_WIDTH]),
        .inc_valid (stat_valid[CH_PER_GROUP +: CH_PER_GROUP]),
        .update    (update),
        .upd_data  (upd_data_1),
        .upd_id    (upd_id_1),
        .upd_valid (upd_valid_1),
        .upd_ready (upd_ready_1)
    );

    stats_arbiter arbiter (
        .clk         (clk),
        .rst         (rst),
        .upd_data_0  (upd_data_0),
        .upd_id_0    (upd_id_0),
        .upd_valid_0 (upd_valid_0),
        .upd_ready_0 (upd_ready_0),
        .upd_data_1  (upd_data_1),
        .upd_id_1    (upd_id_1),
        .upd_valid_1 (upd_valid_1),
        .upd_ready_1 (upd_ready_1),
        .cnt_data    (cnt_data),
        .cnt_id      (cnt_id),
        .cnt_strobe  (cnt_strobe)
    );

    stats_counter counters (
        .clk        (clk),
        .rst        (rst),
        .cnt_data   (cnt_data),
        .cnt_id     (cnt_id),
        .cnt_strobe (cnt_strobe),
        .rd_en      (rd_en),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data),
        .rd_valid   (rd_valid)
    );

endmodule
